/* bench/vmask_ref.svh */
// Vector mask unit reference model
`ifndef VMASK_REF_SVH
`define VMASK_REF_SVH

//////////////////////////////
// Mask register operations
//////////////////////////////

// Bitwise result of vs2 op vs1
function automatic logic [MASK_W-1:0] ref_mask_op(
    input logic [2:0]        op,
    input logic [MASK_W-1:0] src1,
    input logic [MASK_W-1:0] src2
);
    logic [MASK_W-1:0] result;
    case (op)
        MOP_AND:  result = src2 & src1;
        MOP_NAND: result = ~(src2 & src1);
        MOP_ANDN: result = src2 & ~src1;
        MOP_XOR:  result = src2 ^ src1;
        MOP_OR:   result = src2 | src1;
        MOP_NOR:  result = ~(src2 | src1);
        MOP_ORN:  result = src2 | ~src1;
        default:  result = ~(src2 ^ src1);
    endcase
    return result;
endfunction

// Element width in bits, anything unknown counts as 8
function automatic int ref_element_width(input logic [SEW_W-1:0] code);
    int width;
    case (code)
        SEW_16:  width = 16;
        SEW_32:  width = 32;
        SEW_64:  width = 64;
        default: width = 8;
    endcase
    return width;
endfunction

//////////////////////////////
// Masked result word
//////////////////////////////

// Walks the word bit by bit and finds the owning element
function automatic logic [VLEN-1:0] ref_masked_result(
    input logic [VLEN-1:0]   lanes,
    input logic [VLEN-1:0]   dest,
    input logic [MASK_W-1:0] mask,
    input logic [IDX_W-1:0]  start_idx,
    input logic [IDX_W-1:0]  len,
    input logic              tail_agn,
    input logic              mask_agn,
    input logic [SEW_W-1:0]  code,
    input logic              masked
);
    logic [VLEN-1:0] result;
    int              width;
    int              elem;
    int              start_i;
    int              len_i;
    width   = ref_element_width(code);
    start_i = int'(start_idx);
    len_i   = int'(len);
    result  = lanes;
    if (masked) begin
        for (int b = 0; b < VLEN; b++) begin
            elem = b / width;
            if (elem < start_i) begin
                // Prestart keeps the old value
                result[b] = dest[b];
            end else if (elem < len_i) begin
                // Body, inactive elements follow vma
                result[b] = mask[elem] ? lanes[b] : (mask_agn ? 1'b1 : dest[b]);
            end else begin
                result[b] = tail_agn ? 1'b1 : dest[b];
            end
        end
    end
    return result;
endfunction

`endif

/* bench/vmask_tb.sv */
// Vector mask unit testbench
`timescale 1ns/1ps

module vmask_tb;

    import vmask_pkg::*;

    `include "vmask_ref.svh"

    localparam int CLK_PERIOD      = 8;
    localparam int SEED            = 742;
    localparam int RESET_CYCLES    = 5;
    localparam int BYPASS_VECS     = 6;
    localparam int OP_REPS         = 4;
    localparam int SEW_REPS        = 40;
    localparam int MREG_VECS       = 20;
    localparam int EDGE_VECS       = 12;
    localparam int WATCHDOG_MARGIN = 20;
    localparam int TOTAL_VECTORS   = RESET_CYCLES + BYPASS_VECS + 8 * OP_REPS
                                   + 4 * SEW_REPS + MREG_VECS + EDGE_VECS;

    logic              clk;
    logic              arst_n;
    vreg_t             lanes_data;
    vreg_t             dest_data;
    logic [MASK_W-1:0] vs1;
    logic [MASK_W-1:0] vs2;
    logic [MASK_W-1:0] v0;
    logic [2:0]        mask_op;
    logic              mask_en;
    logic              mask_reg_en;
    logic              vta;
    logic              vma;
    logic [IDX_W-1:0]  vstart;
    logic [IDX_W-1:0]  vl;
    logic [SEW_W-1:0]  sew;
    vreg_t             mask_unit_output;
    logic [MASK_W-1:0] mask_reg_updated;

    // Expected outputs for the next rising edge
    logic [VLEN-1:0]   exp_output = '0;
    logic [MASK_W-1:0] exp_mask   = '0;
    logic [MASK_W-1:0] ref_eff;
    int                check_count    = 0;
    int                error_count    = 0;
    int                vectors_driven = 0;

    vmask_unit u_vmask_unit (
        .clk              (clk),
        .arst_n           (arst_n),
        .lanes_data       (lanes_data),
        .dest_data        (dest_data),
        .vs1              (vs1),
        .vs2              (vs2),
        .v0               (v0),
        .mask_op          (mask_op),
        .mask_en          (mask_en),
        .mask_reg_en      (mask_reg_en),
        .vta              (vta),
        .vma              (vma),
        .vstart           (vstart),
        .vl               (vl),
        .sew              (sew),
        .mask_unit_output (mask_unit_output),
        .mask_reg_updated (mask_reg_updated)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Output comparison
    //////////////////////////////

    // Values read here are the ones before this edge's updates
    always @(posedge clk) begin
        check_count++;
        assert (mask_unit_output === exp_output) else begin
            error_count++;
            $display("FAIL t=%0t signal=mask_unit_output expected=%h actual=%h",
                     $time, exp_output, mask_unit_output);
        end
        check_count++;
        assert (mask_reg_updated === exp_mask) else begin
            error_count++;
            $display("FAIL t=%0t signal=mask_reg_updated expected=%h actual=%h",
                     $time, exp_mask, mask_reg_updated);
        end
        // Inputs captured now show up at the next edge
        if (arst_n) begin
            ref_eff    = mask_reg_en ? ref_mask_op(mask_op, vs1, vs2) : v0;
            exp_mask   = ref_mask_op(mask_op, vs1, vs2);
            exp_output = ref_masked_result(lanes_data, dest_data, ref_eff, vstart, vl,
                                           vta, vma, sew, mask_en);
        end else begin
            exp_mask   = '0;
            exp_output = '0;
        end
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic vreg_t random_word();
        vreg_t w;
        for (int k = 0; k < VLEN / 32; k++) begin
            w.e32[k] = $urandom;
        end
        return w;
    endfunction

    // Index from 0 up to 32 inclusive
    function automatic logic [IDX_W-1:0] random_index();
        return IDX_W'($urandom % 33);
    endfunction

    function automatic logic random_bit();
        return 1'($urandom);
    endfunction

    function automatic logic [2:0] random_op();
        return 3'($urandom);
    endfunction

    function automatic logic [SEW_W-1:0] sew_code(input int k);
        logic [SEW_W-1:0] code;
        case (k)
            0:       code = SEW_8;
            1:       code = SEW_16;
            2:       code = SEW_32;
            default: code = SEW_64;
        endcase
        return code;
    endfunction

    // One input set on the next rising edge with random data words
    task automatic drive_vector(
        input logic [2:0]       op,
        input logic             men,
        input logic             mren,
        input logic             ta,
        input logic             ma,
        input logic [IDX_W-1:0] start_idx,
        input logic [IDX_W-1:0] len,
        input logic [SEW_W-1:0] code
    );
        vreg_t             lanes_val;
        vreg_t             dest_val;
        logic [MASK_W-1:0] vs1_val;
        logic [MASK_W-1:0] vs2_val;
        logic [MASK_W-1:0] v0_val;
        lanes_val = random_word();
        dest_val  = random_word();
        vs1_val   = $urandom;
        vs2_val   = $urandom;
        v0_val    = $urandom;
        // v0 is the inverse of the op result so the mask source shows in every bit
        if (mren) begin
            v0_val = ~ref_mask_op(op, vs1_val, vs2_val);
        end
        @(posedge clk);
        lanes_data  <= lanes_val;
        dest_data   <= dest_val;
        vs1         <= vs1_val;
        vs2         <= vs2_val;
        v0          <= v0_val;
        mask_op     <= op;
        mask_en     <= men;
        mask_reg_en <= mren;
        vta         <= ta;
        vma         <= ma;
        vstart      <= start_idx;
        vl          <= len;
        sew         <= code;
        vectors_driven++;
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        void'($urandom(SEED));
        arst_n      = 1'b0;
        lanes_data  = '0;
        dest_data   = '0;
        vs1         = '0;
        vs2         = '0;
        v0          = '0;
        mask_op     = MOP_AND;
        mask_en     = 1'b0;
        mask_reg_en = 1'b0;
        vta         = 1'b0;
        vma         = 1'b0;
        vstart      = '0;
        vl          = '0;
        sew         = SEW_8;

        // Outputs stay zero in reset even with live inputs
        repeat (RESET_CYCLES) begin
            drive_vector(MOP_AND, 1'b1, 1'b0, 1'b1, 1'b1, 6'd0, 6'd32, SEW_8);
        end
        arst_n <= 1'b1;

        // Unmasked bypass
        repeat (BYPASS_VECS) begin
            drive_vector(random_op(), 1'b0, random_bit(), random_bit(), random_bit(),
                         random_index(), random_index(), sew_code(int'($urandom % 4)));
        end

        // Every mask op code
        for (int op = 0; op < 8; op++) begin
            repeat (OP_REPS) begin
                drive_vector(3'(op), 1'b1, random_bit(), random_bit(), random_bit(),
                             random_index(), random_index(), SEW_8);
            end
        end

        // Regions and policies for each element width with v0 as mask
        for (int s = 0; s < 4; s++) begin
            repeat (SEW_REPS) begin
                drive_vector(random_op(), 1'b1, 1'b0, random_bit(), random_bit(),
                             random_index(), random_index(), sew_code(s));
            end
        end

        // Op result as mask
        repeat (MREG_VECS) begin
            drive_vector(random_op(), 1'b1, 1'b1, random_bit(), random_bit(),
                         random_index(), random_index(), sew_code(int'($urandom % 4)));
        end

        // Edge cases
        drive_vector(random_op(), 1'b1, 1'b0, random_bit(), random_bit(), 6'd0, 6'd20, SEW_8);
        drive_vector(random_op(), 1'b1, 1'b0, 1'b1, random_bit(), 6'd0, 6'd0, SEW_16);
        drive_vector(random_op(), 1'b1, 1'b0, random_bit(), 1'b1, 6'd0, 6'd32, SEW_8);
        drive_vector(random_op(), 1'b1, 1'b1, 1'b1, 1'b0, 6'd3, 6'd32, SEW_64);
        drive_vector(random_op(), 1'b1, 1'b0, 1'b1, 1'b1, 6'd10, 6'd5, SEW_8);
        drive_vector(random_op(), 1'b1, 1'b0, 1'b1, 1'b0, 6'd7, 6'd7, SEW_32);
        drive_vector(random_op(), 1'b1, 1'b0, 1'b1, 1'b1, 6'd32, 6'd0, SEW_8);
        // Unknown width codes
        drive_vector(random_op(), 1'b1, 1'b0, 1'b1, 1'b0, 6'd2, 6'd25, 6'b000000);
        drive_vector(random_op(), 1'b1, 1'b0, 1'b0, 1'b1, 6'd1, 6'd30, 6'b001100);
        drive_vector(random_op(), 1'b1, 1'b1, 1'b1, 1'b1, 6'd4, 6'd9, 6'b000001);
        drive_vector(random_op(), 1'b1, 1'b0, 1'b0, 1'b1, 6'd0, 6'd17, 6'b111111);
        drive_vector(random_op(), 1'b0, 1'b0, 1'b1, 1'b1, 6'd5, 6'd12, 6'b000011);

        // Let the last vector reach the outputs and its compare finish
        repeat (2) @(posedge clk);
        @(negedge clk);

        $display("Checks: %0d  Errors: %0d  Vectors: %0d",
                 check_count, error_count, vectors_driven);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Run length bound
    initial begin
        #((TOTAL_VECTORS + WATCHDOG_MARGIN) * CLK_PERIOD);
        $display("Timeout: run did not finish, %0d vectors driven", vectors_driven);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* design/element_policy.sv */
// Per-element write policy
`timescale 1ns/1ps

module element_policy (
    input  vmask_pkg::vreg_t             lanes_data,
    input  vmask_pkg::vreg_t             dest_data,
    input  logic [vmask_pkg::MASK_W-1:0] eff_mask,
    input  logic [vmask_pkg::MASK_W-1:0] prestart_flags,
    input  logic [vmask_pkg::MASK_W-1:0] body_flags,
    input  logic [vmask_pkg::MASK_W-1:0] tail_flags,
    input  logic                         vta,
    input  logic                         vma,
    output vmask_pkg::vreg_t             masked_e8,
    output vmask_pkg::vreg_t             masked_e16,
    output vmask_pkg::vreg_t             masked_e32,
    output vmask_pkg::vreg_t             masked_e64
);

    import vmask_pkg::*;

    // Per element index, take the lane value
    logic [MASK_W-1:0] take_lane;
    // Per element index, write all ones
    logic [MASK_W-1:0] take_ones;

    // Decision is shared by all widths since element i reads flag bit i
    // Neither bit set means the destination value is kept
    always_comb begin
        for (int i = 0; i < MASK_W; i++) begin
            if (prestart_flags[i]) begin
                take_lane[i] = 1'b0;
                take_ones[i] = 1'b0;
            end else if (body_flags[i]) begin
                // Inactive body element follows vma
                take_lane[i] = eff_mask[i];
                take_ones[i] = ~eff_mask[i] & vma;
            end else begin
                // Tail element follows vta
                take_lane[i] = 1'b0;
                take_ones[i] = tail_flags[i] & vta;
            end
        end
    end

    //////////////////////////////
    // One candidate word per SEW
    //////////////////////////////

    for (genvar i = 0; i < VLEN / 8; i++) begin : g_e8
        assign masked_e8.e8[i] = take_ones[i] ? '1 :
                                 take_lane[i] ? lanes_data.e8[i] : dest_data.e8[i];
    end

    for (genvar i = 0; i < VLEN / 16; i++) begin : g_e16
        assign masked_e16.e16[i] = take_ones[i] ? '1 :
                                   take_lane[i] ? lanes_data.e16[i] : dest_data.e16[i];
    end

    for (genvar i = 0; i < VLEN / 32; i++) begin : g_e32
        assign masked_e32.e32[i] = take_ones[i] ? '1 :
                                   take_lane[i] ? lanes_data.e32[i] : dest_data.e32[i];
    end

    for (genvar i = 0; i < VLEN / 64; i++) begin : g_e64
        assign masked_e64.e64[i] = take_ones[i] ? '1 :
                                   take_lane[i] ? lanes_data.e64[i] : dest_data.e64[i];
    end

endmodule

/* design/element_region_gen.sv */
// Element region flags
`timescale 1ns/1ps

module element_region_gen (
    input  logic [vmask_pkg::IDX_W-1:0]  vstart,
    input  logic [vmask_pkg::IDX_W-1:0]  vl,
    output logic [vmask_pkg::MASK_W-1:0] prestart_flags,
    output logic [vmask_pkg::MASK_W-1:0] body_flags,
    output logic [vmask_pkg::MASK_W-1:0] tail_flags
);

    import vmask_pkg::*;

    // Bits at or above vstart
    logic [MASK_W-1:0] from_vstart;
    // Bits at or above vl
    logic [MASK_W-1:0] from_vl;

    // All-ones pattern moved up by each index
    // Shifts past the top leave an empty pattern
    assign from_vstart = {MASK_W{1'b1}} << vstart;
    assign from_vl     = {MASK_W{1'b1}} << vl;

    //////////////////////////////
    // Region split
    //////////////////////////////

    // Elements below vstart are never touched
    assign prestart_flags = ~from_vstart;

    // Active window runs from vstart up to vl
    // Empty when vl is at or below vstart
    assign body_flags = from_vstart & ~from_vl;

    // Everything at or above both vl and vstart
    // With vl <= vstart this is the whole range from vstart up
    assign tail_flags = from_vstart & from_vl;

endmodule

/* design/mask_logic_op.sv */
// Mask register logic operations
`timescale 1ns/1ps

module mask_logic_op (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [vmask_pkg::MASK_W-1:0] vs1,
    input  logic [vmask_pkg::MASK_W-1:0] vs2,
    input  logic [vmask_pkg::MASK_W-1:0] v0,
    input  logic [2:0]                   mask_op,
    input  logic                         mask_reg_en,
    output logic [vmask_pkg::MASK_W-1:0] eff_mask,
    output logic [vmask_pkg::MASK_W-1:0] mask_reg_updated
);

    import vmask_pkg::*;

    // Combinational result of vs2 op vs1
    logic [MASK_W-1:0] op_result;

    // Bitwise operation on the two source masks
    always_comb begin
        case (mask_op)
            MOP_AND:  op_result = vs2 & vs1;
            MOP_NAND: op_result = ~(vs2 & vs1);
            MOP_ANDN: op_result = vs2 & ~vs1;
            MOP_XOR:  op_result = vs2 ^ vs1;
            MOP_OR:   op_result = vs2 | vs1;
            MOP_NOR:  op_result = ~(vs2 | vs1);
            MOP_ORN:  op_result = vs2 | ~vs1;
            MOP_XNOR: op_result = ~(vs2 ^ vs1);
            default:  op_result = '0;
        endcase
    end

    // Mask used by the element policy in this same cycle
    // The new result replaces v0 when mask_reg_en is set
    assign eff_mask = mask_reg_en ? op_result : v0;

    //////////////////////////////
    // Output register
    //////////////////////////////

    // Updated mask appears one cycle after its operands
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mask_reg_updated <= '0;
        end else begin
            mask_reg_updated <= op_result;
        end
    end

endmodule

/* design/result_stage.sv */
// Width select and output register
`timescale 1ns/1ps

module result_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [vmask_pkg::SEW_W-1:0] sew,
    input  logic                        mask_en,
    input  vmask_pkg::vreg_t            lanes_data,
    input  vmask_pkg::vreg_t            masked_e8,
    input  vmask_pkg::vreg_t            masked_e16,
    input  vmask_pkg::vreg_t            masked_e32,
    input  vmask_pkg::vreg_t            masked_e64,
    output vmask_pkg::vreg_t            mask_unit_output
);

    import vmask_pkg::*;

    // Binary width choice, 0 for SEW 8 up to 3 for SEW 64
    logic [1:0] width_sel;
    // Word to be captured on the next edge
    vreg_t      next_output;

    //////////////////////////////
    // SEW decode
    //////////////////////////////

    // Unknown or multi-hot codes behave as SEW 8
    always_comb begin
        case (sew)
            SEW_8:   width_sel = 2'd0;
            SEW_16:  width_sel = 2'd1;
            SEW_32:  width_sel = 2'd2;
            SEW_64:  width_sel = 2'd3;
            default: width_sel = 2'd0;
        endcase
    end

    // Candidate pick and unmasked bypass
    always_comb begin
        if (!mask_en) begin
            // Unmasked instruction writes every lane result
            next_output = lanes_data;
        end else begin
            case (width_sel)
                2'd0:    next_output = masked_e8;
                2'd1:    next_output = masked_e16;
                2'd2:    next_output = masked_e32;
                2'd3:    next_output = masked_e64;
                default: next_output = masked_e8;
            endcase
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    // One cycle from inputs to mask_unit_output
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mask_unit_output <= '0;
        end else begin
            mask_unit_output <= next_output;
        end
    end

endmodule

/* design/vmask_pkg.sv */
// Vector mask unit definitions
package vmask_pkg;

    //////////////////////////////
    // Register geometry
    //////////////////////////////

    // Bits held in one vector register
    localparam int VLEN   = 256;
    // One mask bit per element at the narrowest width
    localparam int MASK_W = VLEN / 8;
    // Wide enough for vstart and vl up to 32
    localparam int IDX_W  = 6;
    localparam int SEW_W  = 6;

    // One-hot element width codes
    localparam logic [SEW_W-1:0] SEW_8  = 6'b000100;
    localparam logic [SEW_W-1:0] SEW_16 = 6'b001000;
    localparam logic [SEW_W-1:0] SEW_32 = 6'b010000;
    localparam logic [SEW_W-1:0] SEW_64 = 6'b100000;

    //////////////////////////////
    // Mask-register operations
    //////////////////////////////

    // Operand order is vs2 op vs1
    localparam logic [2:0] MOP_AND  = 3'd0;
    localparam logic [2:0] MOP_NAND = 3'd1;
    localparam logic [2:0] MOP_ANDN = 3'd2;
    localparam logic [2:0] MOP_XOR  = 3'd3;
    localparam logic [2:0] MOP_OR   = 3'd4;
    localparam logic [2:0] MOP_NOR  = 3'd5;
    localparam logic [2:0] MOP_ORN  = 3'd6;
    localparam logic [2:0] MOP_XNOR = 3'd7;

    // One vector word seen as elements of each width
    // Element 0 sits in the lowest bits of every view
    typedef union packed {
        logic [VLEN/8-1:0][7:0]   e8;
        logic [VLEN/16-1:0][15:0] e16;
        logic [VLEN/32-1:0][31:0] e32;
        logic [VLEN/64-1:0][63:0] e64;
    } vreg_t;

endpackage

/* design/vmask_unit.sv */
// Vector mask unit top
`timescale 1ns/1ps

module vmask_unit (
    input  logic                         clk,
    input  logic                         arst_n,
    // Lane results and the old destination register
    input  vmask_pkg::vreg_t             lanes_data,
    input  vmask_pkg::vreg_t             dest_data,
    // Mask sources
    input  logic [vmask_pkg::MASK_W-1:0] vs1,
    input  logic [vmask_pkg::MASK_W-1:0] vs2,
    input  logic [vmask_pkg::MASK_W-1:0] v0,
    input  logic [2:0]                   mask_op,
    // Instruction controls
    input  logic                         mask_en,
    input  logic                         mask_reg_en,
    // vtype and CSR state
    input  logic                         vta,
    input  logic                         vma,
    input  logic [vmask_pkg::IDX_W-1:0]  vstart,
    input  logic [vmask_pkg::IDX_W-1:0]  vl,
    input  logic [vmask_pkg::SEW_W-1:0]  sew,
    // Registered results
    output vmask_pkg::vreg_t             mask_unit_output,
    output logic [vmask_pkg::MASK_W-1:0] mask_reg_updated
);

    import vmask_pkg::*;

    // Mask seen by the body elements
    logic [MASK_W-1:0] eff_mask;

    // Region of each element index
    logic [MASK_W-1:0] prestart_flags;
    logic [MASK_W-1:0] body_flags;
    logic [MASK_W-1:0] tail_flags;

    // Masked word for each element width
    vreg_t masked_e8;
    vreg_t masked_e16;
    vreg_t masked_e32;
    vreg_t masked_e64;

    //////////////////////////////
    // Mask path
    //////////////////////////////

    mask_logic_op u_mask_logic_op (
        .clk              (clk),
        .arst_n           (arst_n),
        .vs1              (vs1),
        .vs2              (vs2),
        .v0               (v0),
        .mask_op          (mask_op),
        .mask_reg_en      (mask_reg_en),
        .eff_mask         (eff_mask),
        .mask_reg_updated (mask_reg_updated)
    );

    // Prestart, body and tail split from vstart and vl
    element_region_gen u_element_region_gen (
        .vstart         (vstart),
        .vl             (vl),
        .prestart_flags (prestart_flags),
        .body_flags     (body_flags),
        .tail_flags     (tail_flags)
    );

    //////////////////////////////
    // Data path
    //////////////////////////////

    element_policy u_element_policy (
        .lanes_data     (lanes_data),
        .dest_data      (dest_data),
        .eff_mask       (eff_mask),
        .prestart_flags (prestart_flags),
        .body_flags     (body_flags),
        .tail_flags     (tail_flags),
        .vta            (vta),
        .vma            (vma),
        .masked_e8      (masked_e8),
        .masked_e16     (masked_e16),
        .masked_e32     (masked_e32),
        .masked_e64     (masked_e64)
    );

    // Width pick, bypass and the output flop
    result_stage u_result_stage (
        .clk              (clk),
        .arst_n           (arst_n),
        .sew              (sew),
        .mask_en          (mask_en),
        .lanes_data       (lanes_data),
        .masked_e8        (masked_e8),
        .masked_e16       (masked_e16),
        .masked_e32       (masked_e32),
        .masked_e64       (masked_e64),
        .mask_unit_output (mask_unit_output)
    );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the vector mask unit simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f sim.f \
    --top-module vmask_tb \
    -o vmask_sim

./obj_dir/vmask_sim > sim.log 2>&1
cat sim.log

if grep -qF "** FAIL **" sim.log; then
    echo "Simulation reported errors"
    exit 1
fi

echo "Simulation finished without errors"

/* sim.f */
+incdir+bench
design/vmask_pkg.sv
design/mask_logic_op.sv
design/element_region_gen.sv
design/element_policy.sv
design/result_stage.sv
design/vmask_unit.sv
bench/vmask_tb.sv
